/* Bender.yml */
package:
  name: loongarch_mini_cpu

export_include_dirs:
  - .

sources:
  - cpu_pkg.sv
  - regfile.sv
  - fetch_stage.sv
  - decode_exec_stage.sv
  - writeback_stage.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_props.sv
      - tb_cpu_top.sv

/* cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`default_nettype none

// ******************************************************************
// Core configuration
// ******************************************************************

`define CPU_RESET_PC 32'h1c00_0000   // First fetch address after reset
`define CPU_XLEN     32              // Data and address width
`define CPU_NREGS    32              // Architectural integer registers

`default_nettype wire

`endif

/* cpu_pkg.sv */
`include "cpu_macros.svh"
`default_nettype none

package cpu_pkg;

    // ******************************************************************
    // Decoded operations and fetch FSM states
    // ******************************************************************

    typedef enum logic [2:0] {
        OP_ADD_W,
        OP_SUB_W,
        OP_OR,
        OP_ADDI_W,
        OP_LU12I_W,
        OP_BEQ,
        OP_B,
        OP_NOP          // Also used for undefined encodings
    } opcode_e;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_WAIT_ADDR,   // req high, waiting for addr_ok
        FS_WAIT_DATA    // Request accepted, waiting for data_ok
    } fetch_state_e;

    // ******************************************************************
    // Inter-stage buses
    // ******************************************************************

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [31:0]          inst;
    } fs2ds_t;

    typedef struct packed {
        logic                 taken;
        logic [`CPU_XLEN-1:0] target;
    } br_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic                 rf_we;
        logic [4:0]           rf_dest;
        logic [`CPU_XLEN-1:0] rf_wdata;
    } ds2ws_t;

    typedef struct packed {
        logic                 valid;
        logic [4:0]           dest;
        logic [`CPU_XLEN-1:0] wdata;
    } ws_fwd_t;

endpackage

`default_nettype wire

/* cpu_props.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"
`default_nettype none

module cpu_props (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 inst_sram_req,
    input logic [`CPU_XLEN-1:0] inst_sram_addr,
    input logic                 inst_sram_addr_ok,
    input logic                 inst_sram_data_ok,
    input logic [3:0]           debug_wb_rf_we
);

    logic pending;                  // Accepted request still waiting for data_ok
    int   prop_fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (inst_sram_req && inst_sram_addr_ok) begin
            pending <= 1'b1;
        end else if (inst_sram_data_ok) begin
            pending <= 1'b0;
        end
    end

    // ******************************************************************
    // Instruction SRAM protocol and trace shape
    // ******************************************************************

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        inst_sram_req && !inst_sram_addr_ok |=> inst_sram_req && $stable(inst_sram_addr))
        else begin
            prop_fail_count++;
            $error("inst_sram_req dropped or addr changed before addr_ok");
        end

    data_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        inst_sram_data_ok |-> pending)
        else begin
            prop_fail_count++;
            $error("inst_sram_data_ok without an accepted request");
        end

    we_uniform: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_rf_we == 4'h0 || debug_wb_rf_we == 4'hf)
        else begin
            prop_fail_count++;
            $error("debug_wb_rf_we is neither all ones nor all zeros");
        end

endmodule

bind cpu_top cpu_props u_props (.*);

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"
`default_nettype none

module cpu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // Instruction SRAM
    output logic                 inst_sram_req,
    output logic                 inst_sram_wr,
    output logic [1:0]           inst_sram_size,
    output logic [3:0]           inst_sram_wstrb,
    output logic [`CPU_XLEN-1:0] inst_sram_addr,
    output logic [31:0]          inst_sram_wdata,
    input  logic                 inst_sram_addr_ok,
    input  logic                 inst_sram_data_ok,
    input  logic [31:0]          inst_sram_rdata,
    // Write-back trace
    output logic [`CPU_XLEN-1:0] debug_wb_pc,
    output logic [3:0]           debug_wb_rf_we,
    output logic [4:0]           debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic                 ds_allowin;
    logic                 fs2ds_valid;
    logic                 ds2ws_valid;
    fs2ds_t               fs2ds_bus;
    ds2ws_t               ds2ws_bus;
    br_t                  br;
    ws_fwd_t              ws_fwd;
    logic [4:0]           rf_raddr1;
    logic [4:0]           rf_raddr2;
    logic [`CPU_XLEN-1:0] rf_rdata1;
    logic [`CPU_XLEN-1:0] rf_rdata2;
    logic                 rf_we;
    logic [4:0]           rf_waddr;
    logic [`CPU_XLEN-1:0] rf_wdata;

    assign inst_sram_wr    = 1'b0;                      // Word reads only
    assign inst_sram_size  = 2'b10;
    assign inst_sram_wstrb = 4'b0000;
    assign inst_sram_wdata = 32'b0;

    fetch_stage u_fetch (
        .clk, .rst_n,
        .inst_sram_req, .inst_sram_addr, .inst_sram_addr_ok,
        .inst_sram_data_ok, .inst_sram_rdata,
        .br, .ds_allowin, .fs2ds_valid, .fs2ds_bus
    );

    decode_exec_stage u_decode_exec (
        .clk, .rst_n,
        .fs2ds_valid, .fs2ds_bus, .ds_allowin,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .ws_fwd, .br, .ds2ws_valid, .ds2ws_bus
    );

    writeback_stage u_writeback (
        .clk, .rst_n,
        .ds2ws_valid, .ds2ws_bus,
        .rf_we, .rf_waddr, .rf_wdata, .ws_fwd,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    regfile u_regfile (
        .clk,
        .raddr1(rf_raddr1), .rdata1(rf_rdata1),
        .raddr2(rf_raddr2), .rdata2(rf_rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

endmodule

`default_nettype wire

/* decode_exec_stage.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"
`default_nettype none

module decode_exec_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fs2ds_valid,
    input  cpu_pkg::fs2ds_t      fs2ds_bus,
    output logic                 ds_allowin,
    output logic [4:0]           rf_raddr1,
    output logic [4:0]           rf_raddr2,
    input  logic [`CPU_XLEN-1:0] rf_rdata1,
    input  logic [`CPU_XLEN-1:0] rf_rdata2,
    input  cpu_pkg::ws_fwd_t     ws_fwd,
    output cpu_pkg::br_t         br,
    output logic                 ds2ws_valid,
    output cpu_pkg::ds2ws_t      ds2ws_bus
);
    import cpu_pkg::*;

    logic                 ds_valid;
    fs2ds_t               ds_bus;
    logic [31:0]          inst;
    logic [4:0]           rd;
    logic [4:0]           rj;
    logic [4:0]           rk;
    logic [11:0]          si12;
    logic [19:0]          si20;
    logic [15:0]          offs16;
    logic [25:0]          offs26;
    opcode_e              op;
    logic [`CPU_XLEN-1:0] src1;
    logic [`CPU_XLEN-1:0] src2;
    logic [`CPU_XLEN-1:0] alu_result;
    logic [`CPU_XLEN-1:0] br_offs;
    logic                 br_cond;
    logic                 rf_we;

    function automatic logic [`CPU_XLEN-1:0] fwd_sel(
        input logic [4:0]           raddr,
        input logic [`CPU_XLEN-1:0] rf_value,
        input ws_fwd_t              fwd
    );
        if (fwd.valid && (fwd.dest == raddr) && (fwd.dest != 5'd0)) begin
            return fwd.wdata;
        end
        return rf_value;
    endfunction

    // ******************************************************************
    // Stage register
    // ******************************************************************

    assign ds_allowin = 1'b1;                           // Write-back always takes the result

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs2ds_valid && !br.taken;       // Drop the wrong-path instruction
        end
    end

    always_ff @(posedge clk) begin
        if (fs2ds_valid && ds_allowin) begin
            ds_bus <= fs2ds_bus;
        end
    end

    // ******************************************************************
    // Decode
    // ******************************************************************

    assign inst   = ds_bus.inst;
    assign rd     = inst[4:0];
    assign rj     = inst[9:5];
    assign rk     = inst[14:10];
    assign si12   = inst[21:10];
    assign si20   = inst[24:5];
    assign offs16 = inst[25:10];
    assign offs26 = {inst[9:0], inst[25:10]};

    always_comb begin
        op = OP_NOP;
        if (inst[31:15] == 17'h00020) begin
            op = OP_ADD_W;
        end else if (inst[31:15] == 17'h00022) begin
            op = OP_SUB_W;
        end else if (inst[31:15] == 17'h0002a) begin
            op = OP_OR;
        end else if (inst[31:22] == 10'b0000001010) begin
            op = OP_ADDI_W;
        end else if (inst[31:25] == 7'b0001010) begin
            op = OP_LU12I_W;
        end else if (inst[31:26] == 6'b010110) begin
            op = OP_BEQ;
        end else if (inst[31:26] == 6'b010100) begin
            op = OP_B;
        end
    end

    assign rf_raddr1 = rj;
    assign rf_raddr2 = (op == OP_BEQ) ? rd : rk;        // beq compares rj with rd

    assign src1 = fwd_sel(rf_raddr1, rf_rdata1, ws_fwd);
    assign src2 = fwd_sel(rf_raddr2, rf_rdata2, ws_fwd);

    // ******************************************************************
    // Execute and branch resolution
    // ******************************************************************

    always_comb begin
        case (op)
            OP_ADD_W:   alu_result = src1 + src2;
            OP_SUB_W:   alu_result = src1 - src2;
            OP_OR:      alu_result = src1 | src2;
            OP_ADDI_W:  alu_result = src1 + {{20{si12[11]}}, si12};
            OP_LU12I_W: alu_result = {si20, 12'b0};
            default:    alu_result = '0;
        endcase
    end

    assign br_offs = (op == OP_B) ? {{4{offs26[25]}}, offs26, 2'b00}
                                  : {{14{offs16[15]}}, offs16, 2'b00};
    assign br_cond = (op == OP_B) || ((op == OP_BEQ) && (src1 == src2));

    assign br.taken  = ds_valid && br_cond;
    assign br.target = ds_bus.pc + br_offs;

    assign rf_we = (op inside {OP_ADD_W, OP_SUB_W, OP_OR, OP_ADDI_W, OP_LU12I_W})
                   && (rd != 5'd0);

    assign ds2ws_valid        = ds_valid;
    assign ds2ws_bus.pc       = ds_bus.pc;
    assign ds2ws_bus.rf_we    = rf_we;
    assign ds2ws_bus.rf_dest  = rd;
    assign ds2ws_bus.rf_wdata = alu_result;

endmodule

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"
`default_nettype none

module fetch_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 inst_sram_req,
    output logic [`CPU_XLEN-1:0] inst_sram_addr,
    input  logic                 inst_sram_addr_ok,
    input  logic                 inst_sram_data_ok,
    input  logic [31:0]          inst_sram_rdata,
    input  cpu_pkg::br_t         br,
    input  logic                 ds_allowin,
    output logic                 fs2ds_valid,
    output cpu_pkg::fs2ds_t      fs2ds_bus
);
    import cpu_pkg::*;

    fetch_state_e         state;
    logic [`CPU_XLEN-1:0] pc;           // Next fetch address
    logic [`CPU_XLEN-1:0] req_pc;       // Address of the request in flight
    logic                 cancel;       // In-flight request is stale
    logic                 outstanding;
    logic                 out_free;
    logic                 issue;
    logic                 accept;
    logic                 reply;
    logic                 keep;

    assign outstanding = (state == FS_WAIT_DATA);
    assign out_free    = !fs2ds_valid || ds_allowin;    // Output reg empty next cycle
    assign issue       = (state == FS_IDLE) && out_free;
    assign accept      = inst_sram_req && inst_sram_addr_ok;
    assign reply       = outstanding && inst_sram_data_ok;
    assign keep        = reply && !cancel && !br.taken;

    assign inst_sram_req  = (state == FS_WAIT_ADDR);
    assign inst_sram_addr = req_pc;

    // ******************************************************************
    // Request FSM, one fetch outstanding at most
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FS_IDLE;
        end else begin
            case (state)
                FS_IDLE:      state <= issue  ? FS_WAIT_ADDR : FS_IDLE;
                FS_WAIT_ADDR: state <= accept ? FS_WAIT_DATA : FS_WAIT_ADDR;
                FS_WAIT_DATA: state <= reply  ? FS_IDLE : FS_WAIT_DATA;
                default:      state <= FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= `CPU_RESET_PC;
            req_pc <= `CPU_RESET_PC;
        end else begin
            if (br.taken) begin
                pc <= br.target;
            end else if (accept && !cancel) begin
                pc <= pc + 32'd4;
            end
            if (issue) begin
                req_pc <= br.taken ? br.target : pc;    // Address frozen until addr_ok
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cancel <= 1'b0;
        end else if (reply) begin
            cancel <= 1'b0;
        end else if (br.taken && (inst_sram_req || outstanding)) begin
            cancel <= 1'b1;
        end
    end

    // ******************************************************************
    // Instruction output register
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fs2ds_valid <= 1'b0;
        end else if (keep) begin
            fs2ds_valid <= 1'b1;
        end else if (br.taken || ds_allowin) begin
            fs2ds_valid <= 1'b0;                        // Consumed or flushed
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            fs2ds_bus.pc   <= req_pc;
            fs2ds_bus.inst <= inst_sram_rdata;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
cpu_pkg.sv
regfile.sv
fetch_stage.sv
decode_exec_stage.sv
writeback_stage.sv
cpu_top.sv
cpu_props.sv
tb_cpu_top.sv

/* regfile.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"
`default_nettype none

module regfile (
    input  logic                 clk,
    input  logic [4:0]           raddr1,
    output logic [`CPU_XLEN-1:0] rdata1,
    input  logic [4:0]           raddr2,
    output logic [`CPU_XLEN-1:0] rdata2,
    input  logic                 we,
    input  logic [4:0]           waddr,
    input  logic [`CPU_XLEN-1:0] wdata
);

    logic [`CPU_XLEN-1:0] rf [`CPU_NREGS];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            rf[waddr] <= wdata;                         // r0 never written
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

/* tb_cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"
`default_nettype none

module tb_cpu_top;
    import cpu_pkg::*;

    localparam int MEM_WORDS = 64;

    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_t;

    typedef enum logic [1:0] {MEM_IDLE, MEM_ADDR, MEM_DATA} mem_state_e;

    logic        clk;
    logic        rst_n;
    logic        inst_sram_req;
    logic        inst_sram_wr;
    logic [1:0]  inst_sram_size;
    logic [3:0]  inst_sram_wstrb;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic        inst_sram_addr_ok = 1'b0;
    logic        inst_sram_data_ok = 1'b0;
    logic [31:0] inst_sram_rdata = 32'h0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] mem [MEM_WORDS];
    int          prog_len;
    trace_t      exp_q [$];
    logic [31:0] lfsr = 32'h9ef1;
    logic        rand_delays;
    logic        check_en;
    logic        rst_q = 1'b1;           // rst_n as seen at the last rising edge
    logic        req_seen;
    int          err_count = 0;
    int          cycle = 0;
    int          deadline = 64;
    int          pass_count;
    int          fail_count;
    mem_state_e  mem_state = MEM_IDLE;
    int          wait_cnt;
    logic [31:0] req_addr;

    cpu_top dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {6'h3f, addr[25:0] ^ {addr[31:26], 20'h0}};    // Undefined encoding
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `CPU_RESET_PC) >> 2;
        if (idx < MEM_WORDS) begin
            return mem[idx];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_delay(output int d);
        d = 0;
        if (rand_delays) begin
            repeat (2) begin
                lfsr = lfsr_step(lfsr);
                d = (d << 1) | int'(lfsr[0]);
            end
        end
    endtask

    function automatic int total_errors();
        return err_count + dut.u_props.prop_fail_count;
    endfunction

    // ******************************************************************
    // Small assembler and program loading
    // ******************************************************************

    function automatic logic [31:0] add_w(input logic [4:0] rd, rj, rk);
        return {17'h00020, rk, rj, rd};
    endfunction

    function automatic logic [31:0] sub_w(input logic [4:0] rd, rj, rk);
        return {17'h00022, rk, rj, rd};
    endfunction

    function automatic logic [31:0] or_r(input logic [4:0] rd, rj, rk);
        return {17'h0002a, rk, rj, rd};
    endfunction

    function automatic logic [31:0] addi_w(input logic [4:0] rd, rj, input logic [11:0] si12);
        return {10'h00a, si12, rj, rd};
    endfunction

    function automatic logic [31:0] lu12i_w(input logic [4:0] rd, input logic [19:0] si20);
        return {7'h0a, si20, rd};
    endfunction

    function automatic logic [31:0] beq_to(input logic [4:0] rj, rd, input int offs);
        return {6'h16, 16'(offs), rj, rd};                      // offs in words
    endfunction

    function automatic logic [31:0] b_to(input int offs);
        logic [25:0] o;
        o = 26'(offs);
        return {6'h14, o[15:0], o[25:16]};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_program(input int id);
        prog_len = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(`CPU_RESET_PC + 32'(4 * i));
        end
        case (id)
            0: begin
                emit(lu12i_w(1, 20'h12345));
                emit(addi_w(2, 0, 12'h678));
                emit(or_r(3, 1, 2));
                emit(addi_w(4, 0, 12'hfff));
                emit(add_w(5, 3, 4));
                emit(sub_w(6, 2, 3));
                emit(lu12i_w(7, 20'h80000));
                emit(sub_w(8, 7, 2));
                emit(or_r(9, 8, 4));
            end
            1: begin                                            // Each reads the one before
                emit(addi_w(1, 0, 12'd5));
                emit(addi_w(1, 1, 12'd7));
                emit(add_w(2, 1, 1));
                emit(sub_w(3, 2, 1));
                emit(or_r(4, 3, 2));
                emit(addi_w(4, 4, 12'hffd));
                emit(add_w(5, 4, 3));
            end
            2: begin
                emit(addi_w(1, 0, 12'd3));
                emit(addi_w(2, 0, 12'd3));
                emit(addi_w(3, 0, 12'd4));
                emit(beq_to(1, 2, 2));                          // Taken
                emit(addi_w(10, 0, 12'h111));
                emit(beq_to(1, 3, 2));                          // Falls through
                emit(addi_w(11, 0, 12'h022));
                emit(b_to(2));
                emit(addi_w(12, 0, 12'h333));
                emit(add_w(13, 11, 1));
                emit(beq_to(0, 0, 3));
                emit(addi_w(14, 0, 12'd1));
                emit(addi_w(14, 0, 12'd2));
                emit(or_r(15, 13, 11));
                emit(b_to(3));
                emit(addi_w(16, 0, 12'd9));
                emit(b_to(2));
                emit(b_to(-2));                                 // Backward
            end
            default: begin
                emit(addi_w(0, 0, 12'h055));
                emit(lu12i_w(0, 20'habcde));
                emit(32'hffff_ffff);
                emit(32'h0000_0000);
                emit(add_w(1, 0, 0));
                emit(addi_w(2, 0, 12'd1));
                emit(or_r(3, 0, 2));
                emit(32'h5c00_0000);                            // bne is not supported
                emit(sub_w(4, 2, 0));
            end
        endcase
        emit(b_to(0));                                          // Parks the core
    endtask

    // ******************************************************************
    // Golden ISA model
    // ******************************************************************

    function automatic opcode_e decode_op(input logic [31:0] inst);
        if ((inst & 32'hffff_8000) == 32'h0010_0000) return OP_ADD_W;
        if ((inst & 32'hffff_8000) == 32'h0011_0000) return OP_SUB_W;
        if ((inst & 32'hffff_8000) == 32'h0015_0000) return OP_OR;
        if ((inst & 32'hffc0_0000) == 32'h0280_0000) return OP_ADDI_W;
        if ((inst & 32'hfe00_0000) == 32'h1400_0000) return OP_LU12I_W;
        if ((inst & 32'hfc00_0000) == 32'h5800_0000) return OP_BEQ;
        if ((inst & 32'hfc00_0000) == 32'h5000_0000) return OP_B;
        return OP_NOP;
    endfunction

    task automatic build_expected();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] vj;
        logic [31:0] vk;
        logic [31:0] vd;
        logic [31:0] next_pc;
        opcode_e     op;
        trace_t      t;
        bit          done;
        int          steps;
        foreach (regs[i]) begin
            regs[i] = 32'h0;
        end
        exp_q.delete();
        pc = `CPU_RESET_PC;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 2 * MEM_WORDS) begin
            inst = fetch_word(pc);
            op = decode_op(inst);
            vj = regs[inst[9:5]];
            vk = regs[inst[14:10]];
            vd = regs[inst[4:0]];
            next_pc = pc + 32'd4;
            t.pc = pc;
            t.wnum = inst[4:0];
            t.wdata = 32'h0;
            case (op)
                OP_ADD_W:   t.wdata = vj + vk;
                OP_SUB_W:   t.wdata = vj - vk;
                OP_OR:      t.wdata = vj | vk;
                OP_ADDI_W:  t.wdata = vj + 32'($signed(inst[21:10]));
                OP_LU12I_W: t.wdata = inst[24:5] << 12;
                OP_BEQ: begin
                    if (vj == vd) begin
                        next_pc = pc + (32'($signed(inst[25:10])) << 2);
                    end
                end
                OP_B: begin
                    next_pc = pc + (32'($signed({inst[9:0], inst[25:10]})) << 2);
                    done = (next_pc == pc);
                end
                default: ;
            endcase
            t.we = (op inside {OP_ADD_W, OP_SUB_W, OP_OR, OP_ADDI_W, OP_LU12I_W})
                   && (inst[4:0] != 5'd0);
            if (t.we) begin
                regs[inst[4:0]] = t.wdata;
            end
            exp_q.push_back(t);
            pc = next_pc;
            steps++;
        end
    endtask

    // ******************************************************************
    // Instruction SRAM model
    // ******************************************************************

    always @(negedge clk) begin
        inst_sram_addr_ok = 1'b0;
        inst_sram_data_ok = 1'b0;
        if (!rst_q) begin
            mem_state = MEM_IDLE;
        end else begin
            case (mem_state)
                MEM_IDLE, MEM_ADDR: begin
                    if (mem_state == MEM_IDLE && inst_sram_req) begin
                        draw_delay(wait_cnt);
                        mem_state = MEM_ADDR;
                    end
                    if (mem_state == MEM_ADDR) begin
                        if (wait_cnt == 0) begin
                            inst_sram_addr_ok = 1'b1;
                            req_addr = inst_sram_addr;
                            draw_delay(wait_cnt);
                            mem_state = MEM_DATA;
                        end else begin
                            wait_cnt--;
                        end
                    end
                end
                default: begin
                    if (wait_cnt == 0) begin
                        inst_sram_data_ok = 1'b1;
                        inst_sram_rdata = fetch_word(req_addr);
                        mem_state = MEM_IDLE;
                    end else begin
                        wait_cnt--;
                    end
                end
            endcase
        end
    end

    // ******************************************************************
    // Trace and reset checks
    // ******************************************************************

    always @(posedge clk) begin : trace_monitor
        trace_t head;
        rst_q <= rst_n;
        if (!rst_n && !rst_q) begin
            assert (inst_sram_req == 1'b0 && debug_wb_rf_we == 4'h0) else begin
                err_count++;
                $display("ERR %0t: req or trace write enable active in reset", $time);
            end
        end
        assert (inst_sram_wr == 1'b0 && inst_sram_size == 2'b10 &&
                inst_sram_wstrb == 4'h0 && inst_sram_wdata == 32'h0) else begin
            err_count++;
            $display("ERR %0t: SRAM wr %b size %b wstrb %h wdata %h, expected word read",
                     $time, inst_sram_wr, inst_sram_size, inst_sram_wstrb, inst_sram_wdata);
        end
        if (!rst_n) begin
            req_seen <= 1'b0;
        end else if (inst_sram_req && !req_seen) begin
            req_seen <= 1'b1;
            assert (inst_sram_addr == `CPU_RESET_PC) else begin
                err_count++;
                $display("ERR %0t: first fetch addr %h", $time, inst_sram_addr);
            end
        end
        if (check_en && dut.u_writeback.ws_valid) begin
            assert (exp_q.size() > 0) else begin
                err_count++;
                $display("ERR %0t: extra retirement at pc %h", $time, debug_wb_pc);
            end
            if (exp_q.size() > 0) begin
                head = exp_q.pop_front();
                assert (debug_wb_pc == head.pc && debug_wb_rf_we == {4{head.we}}) else begin
                    err_count++;
                    $display("ERR %0t: retired pc %h we %h, expected pc %h we %0d",
                             $time, debug_wb_pc, debug_wb_rf_we, head.pc, head.we);
                end
                if (head.we) begin
                    assert (debug_wb_rf_wnum == head.wnum && debug_wb_rf_wdata == head.wdata)
                    else begin
                        err_count++;
                        $display("ERR %0t: pc %h wrote r%0d=%h, expected r%0d=%h", $time,
                                 head.pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                                 head.wnum, head.wdata);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= deadline) begin
            $display("Timeout: the trace did not complete within the cycle limit");
            $display("Test failures found");
            $finish;
        end
    end

    // ******************************************************************
    // Test sequence
    // ******************************************************************

    task automatic run_test(input string name, input int prog_id, input logic random);
        int errs_before;
        int n_expected;
        errs_before = total_errors();
        rst_n = 1'b0;
        check_en = 1'b0;
        rand_delays = random;
        load_program(prog_id);
        build_expected();
        n_expected = exp_q.size();
        deadline = cycle + 40 * prog_len + 10;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        check_en = 1'b1;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        check_en = 1'b0;
        @(negedge clk);
        if (total_errors() == errs_before) begin
            pass_count++;
            $display("test %-20s pass, %0d retirements", name, n_expected);
        end else begin
            fail_count++;
            $display("test %-20s FAIL, %0d errors", name, total_errors() - errs_before);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        check_en = 1'b0;
        rand_delays = 1'b0;
        pass_count = 0;
        fail_count = 0;
        run_test("alu_straight_line", 0, 1'b0);
        run_test("forwarding_chain", 1, 1'b0);
        run_test("branch_redirect", 2, 1'b0);
        run_test("branch_random_delay", 2, 1'b1);
        run_test("alu_random_delay", 0, 1'b1);
        run_test("r0_and_undefined", 3, 1'b1);
        repeat (4) @(negedge clk);
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && total_errors() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* writeback_stage.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"
`default_nettype none

module writeback_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ds2ws_valid,
    input  cpu_pkg::ds2ws_t      ds2ws_bus,
    output logic                 rf_we,
    output logic [4:0]           rf_waddr,
    output logic [`CPU_XLEN-1:0] rf_wdata,
    output cpu_pkg::ws_fwd_t     ws_fwd,
    output logic [`CPU_XLEN-1:0] debug_wb_pc,
    output logic [3:0]           debug_wb_rf_we,
    output logic [4:0]           debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic   ws_valid;
    ds2ws_t ws_bus;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ds2ws_valid;                    // Always accepts
        end
    end

    always_ff @(posedge clk) begin
        if (ds2ws_valid) begin
            ws_bus <= ds2ws_bus;
        end
    end

    assign rf_we    = ws_valid && ws_bus.rf_we;
    assign rf_waddr = ws_bus.rf_dest;
    assign rf_wdata = ws_bus.rf_wdata;

    assign ws_fwd.valid = rf_we;
    assign ws_fwd.dest  = ws_bus.rf_dest;
    assign ws_fwd.wdata = ws_bus.rf_wdata;

    assign debug_wb_pc       = ws_bus.pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = ws_bus.rf_dest;
    assign debug_wb_rf_wdata = ws_bus.rf_wdata;

endmodule

`default_nettype wire
